// File: tb/mul_input_vectors.txt
# Columns: op (0 MUL, 1 MULH, 2 MULHSU, 3 MULHU), rs1, rs2, expected rd, all hex
# Expected rd is the low or high word of the exact product, per the op's signedness
0 00000000 12345678 00000000
0 00000003 00000007 00000015
0 ffffffff ffffffff 00000001
1 ffffffff ffffffff 00000000
3 ffffffff ffffffff fffffffe
2 ffffffff ffffffff ffffffff
1 80000000 80000000 40000000
0 80000000 80000000 00000000
3 80000000 80000000 40000000
2 80000000 80000000 c0000000
2 00000002 ffffffff 00000001
2 fffffffe 00000003 ffffffff
1 fffffffe 00000003 ffffffff
3 fffffffe 00000003 00000002
0 fffffffe 00000003 fffffffa
0 12345678 00010000 56780000
3 12345678 00010000 00001234
1 7fffffff 7fffffff 3fffffff
1 80000000 7fffffff c0000000
1 00000000 ffffffff 00000000
3 00000001 ffffffff 00000000
0 0000ffff 0000ffff fffe0001

// File: flist.f
+incdir+include
src/mul_pkg.sv
src/mul_pipe_ctrl.sv
src/mul_op_decode.sv
src/mul_product_stage.sv
src/mul_unit_top.sv
tb/tb_mul_unit.sv

// File: run.sh
#!/bin/sh
# Build and run the multiply unit testbench with Verilator

verilator --binary --timing --assert -f flist.f --top-module tb_mul_unit \
    -o sim_mul > build.log 2>&1 \
    && ./obj_dir/sim_mul > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// File: tb/tb_mul_unit.sv
// Multiply unit testbench: vector file stimulus, random stalls, in-order result checks
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module tb_mul_unit;

    localparam integer TIMEOUT = 200;
    localparam integer MAX_VEC = 64;

    logic clk;
    logic rst;
    logic issue_new_request;
    mul_pkg::mul_op_e issue_op;
    logic [`MUL_XLEN-1:0] issue_rs1;
    logic [`MUL_XLEN-1:0] issue_rs2;
    mul_pkg::id_t issue_id;
    mul_pkg::phys_addr_t issue_phys_addr;
    logic issue_ready;
    logic wb_done;
    logic [`MUL_XLEN-1:0] wb_rd;
    mul_pkg::id_t wb_id;
    mul_pkg::phys_addr_t wb_phys_addr;
    logic wb_ack;

    // Vectors from file
    logic [1:0] vec_op [0:MAX_VEC-1];
    logic [`MUL_XLEN-1:0] vec_rs1 [0:MAX_VEC-1];
    logic [`MUL_XLEN-1:0] vec_rs2 [0:MAX_VEC-1];
    logic [`MUL_XLEN-1:0] vec_rd [0:MAX_VEC-1];
    integer num_vec;

    // Outstanding requests, oldest first
    logic [`MUL_XLEN-1:0] exp_rd_q[$];
    mul_pkg::id_t exp_id_q[$];
    mul_pkg::phys_addr_t exp_addr_q[$];
    integer acc_cycle_q[$];
    logic check_lat_q[$];

    integer seed = 95;
    integer ack_seed;
    integer errors = 0;
    integer timeouts = 0;
    integer retired = 0;
    integer issued = 0;
    integer cycle = 0;
    logic ack_always = 1'b0;
    logic lat_phase = 1'b0;
    logic [`MUL_XLEN-1:0] exp_rd_next;

    // Last held writeback
    logic held_last = 1'b0;
    logic [`MUL_XLEN-1:0] held_rd;
    mul_pkg::id_t held_id;
    mul_pkg::phys_addr_t held_addr;

    mul_unit_top mul_unit_top_inst (
        .clk               (clk),
        .rst               (rst),
        .issue_new_request (issue_new_request),
        .issue_op          (issue_op),
        .issue_rs1         (issue_rs1),
        .issue_rs2         (issue_rs2),
        .issue_id          (issue_id),
        .issue_phys_addr   (issue_phys_addr),
        .issue_ready       (issue_ready),
        .wb_done           (wb_done),
        .wb_rd             (wb_rd),
        .wb_id             (wb_id),
        .wb_phys_addr      (wb_phys_addr),
        .wb_ack            (wb_ack)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Writeback acknowledge
    ////////////////////////////////////////

    // Random ack in the stall phase, constant ack in the latency phase
    always @(negedge clk) begin
        if (rst) begin
            wb_ack = 1'b0;
        end else if (ack_always) begin
            wb_ack = 1'b1;
        end else begin
            wb_ack = wb_done && (($random(ack_seed) & 1) == 1);
        end
    end

    ////////////////////////////////////////
    // Monitor and scoreboard
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            cycle = cycle + 1;
            // No result without a request
            if (wb_done) begin
                assert (exp_rd_q.size() > 0) else begin
                    $display("mismatch at %0t: wb_done with no outstanding request", $time);
                    errors++;
                end
            end
            // Held result must not move
            if (held_last) begin
                assert (wb_done && wb_rd == held_rd && wb_id == held_id
                        && wb_phys_addr == held_addr) else begin
                    $display("mismatch at %0t: held writeback changed", $time);
                    errors++;
                end
            end
            // Both stages full and stalled
            if (exp_rd_q.size() == 2 && !wb_ack) begin
                assert (!issue_ready) else begin
                    $display("mismatch at %0t: issue_ready high with two held", $time);
                    errors++;
                end
            end
            if (wb_done && wb_ack && exp_rd_q.size() > 0) begin
                assert (wb_rd == exp_rd_q[0]) else begin
                    $display("mismatch at %0t: rd %h expected %h", $time, wb_rd, exp_rd_q[0]);
                    errors++;
                end
                assert (wb_id == exp_id_q[0] && wb_phys_addr == exp_addr_q[0]) else begin
                    $display("mismatch at %0t: id %0d addr %0d expected id %0d addr %0d",
                             $time, wb_id, wb_phys_addr, exp_id_q[0], exp_addr_q[0]);
                    errors++;
                end
                if (check_lat_q[0]) begin
                    assert (cycle == acc_cycle_q[0] + 2) else begin
                        $display("mismatch at %0t: latency %0d cycles expected 2",
                                 $time, cycle - acc_cycle_q[0]);
                        errors++;
                    end
                end
                void'(exp_rd_q.pop_front());
                void'(exp_id_q.pop_front());
                void'(exp_addr_q.pop_front());
                void'(acc_cycle_q.pop_front());
                void'(check_lat_q.pop_front());
                retired++;
            end
            held_last = wb_done && !wb_ack;
            held_rd = wb_rd;
            held_id = wb_id;
            held_addr = wb_phys_addr;
            if (issue_new_request && issue_ready) begin
                exp_rd_q.push_back(exp_rd_next);
                exp_id_q.push_back(issue_id);
                exp_addr_q.push_back(issue_phys_addr);
                acc_cycle_q.push_back(cycle);
                check_lat_q.push_back(lat_phase);
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic load_vectors();
        integer fd;
        integer n;
        string line;
        logic [31:0] f_op;
        logic [31:0] f_rs1;
        logic [31:0] f_rs2;
        logic [31:0] f_rd;
        fd = $fopen("tb/mul_input_vectors.txt", "r");
        num_vec = 0;
        if (fd == 0) begin
            $display("ERROR: cannot open vector file tb/mul_input_vectors.txt");
            timeouts++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h", f_op, f_rs1, f_rs2, f_rd);
                    if (n == 4 && num_vec < MAX_VEC) begin
                        vec_op[num_vec] = f_op[1:0];
                        vec_rs1[num_vec] = f_rs1;
                        vec_rs2[num_vec] = f_rs2;
                        vec_rd[num_vec] = f_rd;
                        num_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Offer one request and wait for acceptance
    task automatic offer_request(input integer idx);
        integer wait_cnt;
        logic accepted;
        @(negedge clk);
        issue_new_request = 1'b1;
        issue_op = mul_pkg::mul_op_e'(vec_op[idx % num_vec]);
        issue_rs1 = vec_rs1[idx % num_vec];
        issue_rs2 = vec_rs2[idx % num_vec];
        exp_rd_next = vec_rd[idx % num_vec];
        issue_id = mul_pkg::id_t'(idx % 8);
        issue_phys_addr = mul_pkg::phys_addr_t'(idx % 64);
        wait_cnt = 0;
        accepted = 1'b0;
        while (!accepted && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            if (issue_ready) accepted = 1'b1;
            else wait_cnt++;
        end
        if (!accepted) begin
            $display("ERROR: request %0d was never accepted", idx);
            timeouts++;
        end else if (lat_phase) begin
            assert (wait_cnt == 0) else begin
                $display("mismatch at %0t: request %0d stalled with ack high", $time, idx);
                errors++;
            end
        end
        issued++;
    endtask

    // Drain all outstanding results
    task automatic wait_drain();
        integer wait_cnt;
        wait_cnt = 0;
        while (exp_rd_q.size() > 0 && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_rd_q.size() > 0) begin
            $display("ERROR: no writeback for request, %0d outstanding", exp_rd_q.size());
            timeouts++;
        end
    endtask

    initial begin
        integer i;
        integer gap;
        ack_seed = seed + 1;
        clk = 1'b0;
        rst = 1'b1;
        issue_new_request = 1'b0;
        issue_op = mul_pkg::MUL;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_id = '0;
        issue_phys_addr = '0;
        exp_rd_next = '0;
        wb_ack = 1'b0;
        load_vectors();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!wb_done && issue_ready) else begin
            $display("mismatch at %0t: bad state after reset", $time);
            errors++;
        end
        // Random gaps and random back-pressure
        for (i = 0; i < num_vec; i++) begin
            gap = $random(seed) & 3;
            if (gap == 0) begin
                @(negedge clk);
                issue_new_request = 1'b0;
                repeat (($random(seed) & 3) + 1) @(negedge clk);
            end
            offer_request(i);
        end
        @(negedge clk);
        issue_new_request = 1'b0;
        wait_drain();
        // Back-to-back with ack held, fixed two-cycle latency
        ack_always = 1'b1;
        @(negedge clk);
        lat_phase = 1'b1;
        for (i = num_vec; i < 2 * num_vec; i++) begin
            offer_request(i);
        end
        @(negedge clk);
        issue_new_request = 1'b0;
        lat_phase = 1'b0;
        wait_drain();
        repeat (5) @(posedge clk);
        assert (retired == issued && num_vec > 0) else begin
            $display("mismatch at %0t: issued %0d retired %0d", $time, issued, retired);
            errors++;
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d retired", errors, timeouts, retired);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/mul_unit_top.sv
// Multiply execution unit: two-stage RV32M multiply with issue and writeback
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_unit_top (
    input  wire logic                 clk,
    input  wire logic                 rst,

    // Issue side
    input  wire logic                 issue_new_request,
    input  wire mul_pkg::mul_op_e     issue_op,
    input  wire logic [`MUL_XLEN-1:0] issue_rs1,
    input  wire logic [`MUL_XLEN-1:0] issue_rs2,
    input  wire mul_pkg::id_t         issue_id,
    input  wire mul_pkg::phys_addr_t  issue_phys_addr,
    output logic                      issue_ready,

    // Writeback side
    output logic                      wb_done,
    output logic [`MUL_XLEN-1:0]      wb_rd,
    output mul_pkg::id_t              wb_id,
    output mul_pkg::phys_addr_t       wb_phys_addr,
    input  wire logic                 wb_ack
);

    // Advance strobes from control
    logic stage1_advance;
    logic stage2_advance;

    // Stage 1 to stage 2
    logic signed [`MUL_XLEN:0] rs1_r;
    logic signed [`MUL_XLEN:0] rs2_r;
    logic                      mulh_r;
    mul_pkg::id_t              id_r;
    mul_pkg::phys_addr_t       phys_addr_r;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    mul_pipe_ctrl mul_pipe_ctrl_inst (
        .clk               (clk),
        .rst               (rst),
        .issue_new_request (issue_new_request),
        .wb_ack            (wb_ack),
        .stage1_advance    (stage1_advance),
        .stage2_advance    (stage2_advance),
        .issue_ready       (issue_ready),
        .wb_done           (wb_done)
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    // Decode and operand registers
    mul_op_decode mul_op_decode_inst (
        .clk            (clk),
        .stage1_advance (stage1_advance),
        .op             (issue_op),
        .rs1            (issue_rs1),
        .rs2            (issue_rs2),
        .id             (issue_id),
        .phys_addr      (issue_phys_addr),
        .rs1_r          (rs1_r),
        .rs2_r          (rs2_r),
        .mulh_r         (mulh_r),
        .id_r           (id_r),
        .phys_addr_r    (phys_addr_r)
    );

    // Product and writeback select
    mul_product_stage mul_product_stage_inst (
        .clk            (clk),
        .stage2_advance (stage2_advance),
        .rs1_r          (rs1_r),
        .rs2_r          (rs2_r),
        .mulh_r         (mulh_r),
        .id_r           (id_r),
        .phys_addr_r    (phys_addr_r),
        .rd             (wb_rd),
        .id             (wb_id),
        .phys_addr      (wb_phys_addr)
    );

endmodule

`default_nettype wire

// File: src/mul_product_stage.sv
// Multiply stage 2: registered 33x33 signed product and result half select
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_product_stage (
    input  wire logic                      clk,
    input  wire logic                      stage2_advance,
    input  wire logic signed [`MUL_XLEN:0] rs1_r,
    input  wire logic signed [`MUL_XLEN:0] rs2_r,
    input  wire logic                      mulh_r,
    input  wire mul_pkg::id_t              id_r,
    input  wire mul_pkg::phys_addr_t       phys_addr_r,
    output logic [`MUL_XLEN-1:0]           rd,
    output mul_pkg::id_t                   id,
    output mul_pkg::phys_addr_t            phys_addr
);

    // Product register, written whole, read per half
    mul_pkg::mul_product_u product_r;

    // Stage 2 attributes
    logic                high_r;
    mul_pkg::id_t        id_q;
    mul_pkg::phys_addr_t phys_addr_q;

    ////////////////////////////////////////
    // Multiply and register
    ////////////////////////////////////////

    // Both operands signed and 33 bits wide
    // Upper two product bits never matter, so 64 bits suffice
    always_ff @(posedge clk) begin
        if (stage2_advance) begin
            product_r.full <= rs1_r * rs2_r;
        end
    end

    // Attributes move with the product
    always_ff @(posedge clk) begin
        if (stage2_advance) begin
            high_r      <= mulh_r;
            id_q        <= id_r;
            phys_addr_q <= phys_addr_r;
        end
    end

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////

    // MULH variants take the upper word
    always_comb begin
        if (high_r) begin
            rd = product_r.half.hi;
        end else begin
            rd = product_r.half.lo;
        end
    end

    assign id        = id_q;
    assign phys_addr = phys_addr_q;

endmodule

`default_nettype wire

// File: src/mul_op_decode.sv
// Multiply stage 1: signedness decode, operand extension and input registers
`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_op_decode (
    input  wire logic                      clk,
    input  wire logic                      stage1_advance,
    input  wire mul_pkg::mul_op_e          op,
    input  wire logic [`MUL_XLEN-1:0]      rs1,
    input  wire logic [`MUL_XLEN-1:0]      rs2,
    input  wire mul_pkg::id_t              id,
    input  wire mul_pkg::phys_addr_t       phys_addr,
    output logic signed [`MUL_XLEN:0]      rs1_r,
    output logic signed [`MUL_XLEN:0]      rs2_r,
    output logic                           mulh_r,
    output mul_pkg::id_t                   id_r,
    output mul_pkg::phys_addr_t            phys_addr_r
);

    // Per operand signedness
    logic rs1_signed;
    logic rs2_signed;

    // Operands widened by one bit
    logic signed [`MUL_XLEN:0] rs1_ext;
    logic signed [`MUL_XLEN:0] rs2_ext;

    // Result comes from the upper half
    logic is_high;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    // MUL keeps only the low half, so its rs1 sign is irrelevant
    assign rs1_signed = (op == mul_pkg::MULH) || (op == mul_pkg::MULHSU);

    // Signed rs2 for MUL and MULH, unsigned for the rest
    assign rs2_signed = (op == mul_pkg::MUL) || (op == mul_pkg::MULH);

    // Every op except MUL returns the high word
    assign is_high = (op != mul_pkg::MUL);

    ////////////////////////////////////////
    // Operand extension
    ////////////////////////////////////////

    // Sign bit or zero on top, so one signed multiplier
    // covers signed, unsigned and mixed cases
    assign rs1_ext = {rs1[`MUL_XLEN-1] & rs1_signed, rs1};
    assign rs2_ext = {rs2[`MUL_XLEN-1] & rs2_signed, rs2};

    ////////////////////////////////////////
    // Stage 1 registers
    ////////////////////////////////////////

    // Hold while stage 1 is stalled
    always_ff @(posedge clk) begin
        if (stage1_advance) begin
            rs1_r       <= rs1_ext;
            rs2_r       <= rs2_ext;
            mulh_r      <= is_high;
            id_r        <= id;
            phys_addr_r <= phys_addr;
        end
    end

endmodule

`default_nettype wire

// File: src/mul_pipe_ctrl.sv
// Multiply pipeline control: stage valid bits and stage advance decisions
`timescale 1ns/1ps
`default_nettype none

module mul_pipe_ctrl (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic issue_new_request,
    input  wire logic wb_ack,
    output logic      stage1_advance,
    output logic      stage2_advance,
    output logic      issue_ready,
    output logic      wb_done
);

    // Stage occupancy
    logic valid_1;
    logic valid_2;

    ////////////////////////////////////////
    // Advance decisions
    ////////////////////////////////////////

    // Stage 2 moves when empty or its result leaves
    assign stage2_advance = ~valid_2 | wb_ack;

    // Stage 1 moves when empty or stage 2 takes its contents
    assign stage1_advance = ~valid_1 | stage2_advance;

    // Accept only when stage 1 can load
    assign issue_ready = stage1_advance;

    ////////////////////////////////////////
    // Valid bits
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_1 <= 1'b0;
            valid_2 <= 1'b0;
        end else begin
            // Stage 1 loads the request strobe, a bubble if none
            if (stage1_advance) begin
                valid_1 <= issue_new_request;
            end
            // Stage 2 inherits stage 1 occupancy
            if (stage2_advance) begin
                valid_2 <= valid_1;
            end
        end
    end

    // Result held until acked
    assign wb_done = valid_2;

endmodule

`default_nettype wire

// File: src/mul_pkg.sv
// Multiply unit types: operation encoding, attribute types and product word
`default_nettype none

`include "mul_consts.svh"

package mul_pkg;

    ////////////////////////////////////////
    // Operation encoding
    ////////////////////////////////////////

    // Low two bits of funct3 for the RV32M multiplies
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_op_e;

    // Attributes that travel beside the operands
    typedef logic [`MUL_ID_W-1:0] id_t;
    typedef logic [`MUL_PHYS_ADDR_W-1:0] phys_addr_t;

    ////////////////////////////////////////
    // Product word
    ////////////////////////////////////////

    // Upper and lower result halves
    typedef struct packed {
        logic [`MUL_XLEN-1:0] hi;
        logic [`MUL_XLEN-1:0] lo;
    } mul_halves_t;

    // Written as one signed value, read back per half
    typedef union packed {
        logic signed [2*`MUL_XLEN-1:0] full;
        mul_halves_t half;
    } mul_product_u;

endpackage

`default_nettype wire

// File: include/mul_consts.svh
// Multiply unit constants: data, instruction id and register address widths
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Operand and result width, RV32
`define MUL_XLEN 32

////////////////////////////////////////
// Attribute widths
////////////////////////////////////////

// Instruction id, up to eight in flight core wide
`define MUL_ID_W 3

// Physical destination register address
`define MUL_PHYS_ADDR_W 6

`endif
